// ==== cpu_pkg.sv ====
// Shared definitions for the reduced 6502 core
// Bus widths, opcode values, sequencer states, ALU operations,
// addressing modes, register selects, flag classes and status bits

package cpu_pkg;

  // ------------------------------------------------------------
  // Bus widths and word types
  // ------------------------------------------------------------
  localparam int addr_w = 16;
  localparam int data_w = 8;

  typedef logic [addr_w-1:0] addr_t;
  typedef logic [data_w-1:0] data_t;

  // ------------------------------------------------------------
  // Opcodes of the supported subset
  // ------------------------------------------------------------
  // Implied
  localparam data_t op_clc     = 8'h18;
  localparam data_t op_sec     = 8'h38;
  localparam data_t op_clv     = 8'hb8;
  localparam data_t op_nop     = 8'hea;
  // Immediate loads
  localparam data_t op_lda_imm = 8'ha9;
  localparam data_t op_ldx_imm = 8'ha2;
  localparam data_t op_ldy_imm = 8'ha0;
  // Absolute loads and stores
  localparam data_t op_lda_abs = 8'had;
  localparam data_t op_ldx_abs = 8'hae;
  localparam data_t op_ldy_abs = 8'hac;
  localparam data_t op_sta_abs = 8'h8d;
  localparam data_t op_stx_abs = 8'h8e;
  localparam data_t op_sty_abs = 8'h8c;
  // Jump
  localparam data_t op_jmp_abs = 8'h4c;
  // Absolute arithmetic and logic on A
  localparam data_t op_adc_abs = 8'h6d;
  localparam data_t op_sbc_abs = 8'hed;
  localparam data_t op_and_abs = 8'h2d;
  localparam data_t op_ora_abs = 8'h0d;
  localparam data_t op_eor_abs = 8'h4d;

  // ------------------------------------------------------------
  // Sequencer states
  // ------------------------------------------------------------
  typedef enum logic [2:0] {
    reset     = 3'd0,
    vector_lo = 3'd1,
    vector_hi = 3'd2,
    fetch     = 3'd3,
    decode    = 3'd4,
    abs_1     = 3'd5,
    abs_2     = 3'd6,
    trap      = 3'd7
  } state_t;

  // ALU operations, pass forwards the B input
  typedef enum logic [2:0] {
    pass   = 3'd0,
    add    = 3'd1,
    and_op = 3'd2,
    or_op  = 3'd3,
    xor_op = 3'd4
  } alu_op_t;

  // Addressing mode picks the path through the sequencer
  typedef enum logic [2:0] {
    implied   = 3'd0,
    immediate = 3'd1,
    absolute  = 3'd2,
    jump      = 3'd3,
    illegal   = 3'd4
  } addr_mode_t;

  // Load destination or store source
  typedef enum logic [1:0] {
    none = 2'd0,
    a    = 2'd1,
    x    = 2'd2,
    y    = 2'd3
  } reg_sel_t;

  // Which status bits an instruction touches
  typedef enum logic [1:0] {
    keep_flags = 2'd0,
    nz         = 2'd1,
    nzcv       = 2'd2,
    single     = 2'd3
  } flag_cls_t;

  // Status register bit positions
  localparam int carry  = 0;
  localparam int zero   = 1;
  localparam int unused = 5;
  localparam int ovf    = 6;
  localparam int neg    = 7;

endpackage

// ==== cpu_alu.sv ====
// Combinational 8-bit ALU
// Add with carry, AND, OR, XOR and pass of the B input

`timescale 1ns/1ns

module cpu_alu (
  input  cpu_pkg::alu_op_t op,
  input  cpu_pkg::data_t   ai,
  input  cpu_pkg::data_t   bi,
  input  logic             carry_in,
  output cpu_pkg::data_t   y,
  output logic             carry_out,
  output logic             overflow
);

  // One extra bit to catch the carry
  logic [cpu_pkg::data_w:0] sum;

  assign sum = {1'b0, ai} + {1'b0, bi} + {{cpu_pkg::data_w{1'b0}}, carry_in};

  always_comb begin
    // Logic ops leave carry and overflow low
    y = bi;
    carry_out = 1'b0;
    overflow = 1'b0;
    case (op)
      cpu_pkg::add: begin
        y = sum[cpu_pkg::data_w-1:0];
        carry_out = sum[cpu_pkg::data_w];
        // Signed overflow when both inputs agree in sign and the result does not
        overflow = (ai[cpu_pkg::data_w-1] == bi[cpu_pkg::data_w-1]) &&
                   (y[cpu_pkg::data_w-1] != ai[cpu_pkg::data_w-1]);
      end
      cpu_pkg::and_op: y = ai & bi;
      cpu_pkg::or_op: y = ai | bi;
      cpu_pkg::xor_op: y = ai ^ bi;
      default: y = bi;
    endcase
  end

endmodule

// ==== opcode_decoder.sv ====
// Opcode table for the supported instruction subset
// Maps the instruction register to mode, ALU op, registers and flag class

`timescale 1ns/1ns

module opcode_decoder (
  input  cpu_pkg::data_t      ir,
  output cpu_pkg::addr_mode_t mode,
  output cpu_pkg::alu_op_t    alu_op,
  output cpu_pkg::reg_sel_t   dest,
  output cpu_pkg::reg_sel_t   store_src,
  output cpu_pkg::flag_cls_t  flag_cls
);

  always_comb begin
    // Anything not listed below is an illegal opcode
    mode = cpu_pkg::illegal;
    alu_op = cpu_pkg::pass;
    dest = cpu_pkg::none;
    store_src = cpu_pkg::none;
    flag_cls = cpu_pkg::keep_flags;

    case (ir)
      // ------------------------------------------------------------
      // Implied
      // ------------------------------------------------------------
      cpu_pkg::op_nop: begin
        mode = cpu_pkg::implied;
      end
      cpu_pkg::op_clc, cpu_pkg::op_sec, cpu_pkg::op_clv: begin
        mode = cpu_pkg::implied;
        // Which flag, and which value, comes from the opcode itself
        flag_cls = cpu_pkg::single;
      end

      // ------------------------------------------------------------
      // Loads, immediate and absolute
      // ------------------------------------------------------------
      cpu_pkg::op_lda_imm, cpu_pkg::op_ldx_imm, cpu_pkg::op_ldy_imm,
      cpu_pkg::op_lda_abs, cpu_pkg::op_ldx_abs, cpu_pkg::op_ldy_abs: begin
        // Bit 2 is set in the absolute forms of all three loads
        mode = ir[2] ? cpu_pkg::absolute : cpu_pkg::immediate;
        flag_cls = cpu_pkg::nz;
        // Low opcode bits name the target register
        case (ir[1:0])
          2'b01: dest = cpu_pkg::a;
          2'b10: dest = cpu_pkg::x;
          default: dest = cpu_pkg::y;
        endcase
      end

      // Stores
      cpu_pkg::op_sta_abs: begin
        mode = cpu_pkg::absolute;
        store_src = cpu_pkg::a;
      end
      cpu_pkg::op_stx_abs: begin
        mode = cpu_pkg::absolute;
        store_src = cpu_pkg::x;
      end
      cpu_pkg::op_sty_abs: begin
        mode = cpu_pkg::absolute;
        store_src = cpu_pkg::y;
      end

      cpu_pkg::op_jmp_abs: begin
        mode = cpu_pkg::jump;
      end

      // ------------------------------------------------------------
      // Accumulator arithmetic and logic
      // ------------------------------------------------------------
      cpu_pkg::op_adc_abs, cpu_pkg::op_sbc_abs: begin
        mode = cpu_pkg::absolute;
        alu_op = cpu_pkg::add;
        dest = cpu_pkg::a;
        flag_cls = cpu_pkg::nzcv;
      end
      cpu_pkg::op_and_abs, cpu_pkg::op_ora_abs, cpu_pkg::op_eor_abs: begin
        mode = cpu_pkg::absolute;
        dest = cpu_pkg::a;
        flag_cls = cpu_pkg::nz;
        if (ir == cpu_pkg::op_and_abs) begin
          alu_op = cpu_pkg::and_op;
        end else if (ir == cpu_pkg::op_ora_abs) begin
          alu_op = cpu_pkg::or_op;
        end else begin
          alu_op = cpu_pkg::xor_op;
        end
      end

      default: begin
      end
    endcase
  end

endmodule

// ==== cpu_regs.sv ====
// Architectural registers A, X, Y and status
// Result write-back, flag update and store source select

`timescale 1ns/1ns

module cpu_regs (
  input  logic                clk,
  input  logic                resetn,
  input  logic                reg_write,
  input  cpu_pkg::data_t      operand,
  input  cpu_pkg::data_t      ir,
  input  cpu_pkg::alu_op_t    alu_op,
  input  cpu_pkg::reg_sel_t   dest,
  input  cpu_pkg::flag_cls_t  flag_cls,
  input  cpu_pkg::reg_sel_t   store_src,
  output cpu_pkg::data_t      store_data,
  output cpu_pkg::data_t      status
);

  cpu_pkg::data_t a_reg;
  cpu_pkg::data_t x_reg;
  cpu_pkg::data_t y_reg;
  cpu_pkg::data_t p_reg;
  cpu_pkg::data_t alu_b;
  cpu_pkg::data_t result;
  logic           alu_c;
  logic           alu_v;

  // SBC is A + ~M + C, carry acting as inverted borrow
  assign alu_b = (ir == cpu_pkg::op_sbc_abs) ? ~operand : operand;

  cpu_alu u_alu (
    .op        (alu_op),
    .ai        (a_reg),
    .bi        (alu_b),
    .carry_in  (p_reg[cpu_pkg::carry]),
    .y         (result),
    .carry_out (alu_c),
    .overflow  (alu_v)
  );

  // ------------------------------------------------------------
  // Register write-back
  // ------------------------------------------------------------
  always_ff @(posedge clk) begin
    if (reg_write && dest == cpu_pkg::a) begin
      a_reg <= result;
    end
  end

  always_ff @(posedge clk) begin
    if (!resetn) begin
      x_reg <= '0;
      y_reg <= '0;
      // Bit 5 reads as one
      p_reg <= 8'h20;
    end else if (reg_write) begin
      if (dest == cpu_pkg::x) begin
        x_reg <= result;
      end
      if (dest == cpu_pkg::y) begin
        y_reg <= result;
      end
      // Flags by class
      case (flag_cls)
        cpu_pkg::nz, cpu_pkg::nzcv: begin
          p_reg[cpu_pkg::neg] <= result[cpu_pkg::data_w-1];
          p_reg[cpu_pkg::zero] <= (result == '0);
          if (flag_cls == cpu_pkg::nzcv) begin
            p_reg[cpu_pkg::carry] <= alu_c;
            p_reg[cpu_pkg::ovf] <= alu_v;
          end
        end
        cpu_pkg::single: begin
          if (ir == cpu_pkg::op_clv) begin
            p_reg[cpu_pkg::ovf] <= 1'b0;
          end else begin
            // SEC sets, CLC clears
            p_reg[cpu_pkg::carry] <= (ir == cpu_pkg::op_sec);
          end
        end
        default: begin
        end
      endcase
    end
  end

  // Store source select for the write port
  always_comb begin
    case (store_src)
      cpu_pkg::x: store_data = x_reg;
      cpu_pkg::y: store_data = y_reg;
      default: store_data = a_reg;
    endcase
  end

  assign status = p_reg;

endmodule

// ==== cpu_sequencer.sv ====
// Multi-cycle instruction sequencer
// State machine, program counter, instruction and operand registers,
// memory address and write port drive

`timescale 1ns/1ns

module cpu_sequencer #(
  parameter cpu_pkg::addr_t VECTOR_ADDR = 16'hfffc
) (
  input  logic                clk,
  input  logic                resetn,
  input  cpu_pkg::data_t      rd_data,
  input  cpu_pkg::addr_mode_t mode,
  input  cpu_pkg::reg_sel_t   store_src,
  input  cpu_pkg::data_t      store_data,
  output cpu_pkg::data_t      ir,
  output cpu_pkg::data_t      operand,
  output logic                reg_write,
  output cpu_pkg::addr_t      address,
  output cpu_pkg::data_t      wr_data,
  output logic                wr_enable,
  output logic                sync,
  output logic                halted
);

  cpu_pkg::state_t state;
  // PC points at the opcode of the current instruction
  cpu_pkg::addr_t  pc;
  cpu_pkg::data_t  opnd_lo;
  logic            is_store;

  assign is_store = (store_src != cpu_pkg::none);

  // Byte on the bus is the immediate value in decode, the memory value in abs_2
  assign operand = rd_data;

  assign sync = (state == cpu_pkg::fetch);
  assign halted = (state == cpu_pkg::trap);

  // Write-back strobe in the last state of each register-writing instruction
  assign reg_write =
    ((state == cpu_pkg::decode) &&
     (mode == cpu_pkg::implied || mode == cpu_pkg::immediate)) ||
    ((state == cpu_pkg::abs_2) && (mode == cpu_pkg::absolute) && !is_store);

  // ------------------------------------------------------------
  // State, address and write enable
  // ------------------------------------------------------------
  always_ff @(posedge clk) begin
    if (!resetn) begin
      state <= cpu_pkg::reset;
      // Vector low byte is on the bus as soon as reset lifts
      address <= VECTOR_ADDR;
      wr_enable <= 1'b0;
    end else begin
      case (state)
        cpu_pkg::reset: begin
          state <= cpu_pkg::vector_lo;
        end
        cpu_pkg::vector_lo: begin
          state <= cpu_pkg::vector_hi;
          address <= VECTOR_ADDR + 16'd1;
        end
        cpu_pkg::vector_hi: begin
          state <= cpu_pkg::fetch;
          address <= {rd_data, pc[7:0]};
        end
        cpu_pkg::fetch: begin
          state <= cpu_pkg::decode;
          address <= pc + 16'd1;
        end
        cpu_pkg::decode: begin
          case (mode)
            cpu_pkg::implied: begin
              state <= cpu_pkg::fetch;
              address <= pc + 16'd1;
            end
            cpu_pkg::immediate: begin
              state <= cpu_pkg::fetch;
              address <= pc + 16'd2;
            end
            cpu_pkg::absolute, cpu_pkg::jump: begin
              // Operand high byte next
              state <= cpu_pkg::abs_1;
              address <= pc + 16'd2;
            end
            default: state <= cpu_pkg::trap;
          endcase
        end
        cpu_pkg::abs_1: begin
          // High byte goes straight into the address
          address <= {rd_data, opnd_lo};
          if (mode == cpu_pkg::jump) begin
            state <= cpu_pkg::fetch;
          end else begin
            state <= cpu_pkg::abs_2;
            // Stores write for the whole of abs_2
            wr_enable <= is_store;
          end
        end
        cpu_pkg::abs_2: begin
          state <= cpu_pkg::fetch;
          address <= pc + 16'd3;
          wr_enable <= 1'b0;
        end
        // Trap holds forever
        default: state <= cpu_pkg::trap;
      endcase
    end
  end

  // ------------------------------------------------------------
  // Program counter and captured bytes
  // ------------------------------------------------------------
  always_ff @(posedge clk) begin
    case (state)
      cpu_pkg::vector_lo: pc[7:0] <= rd_data;
      cpu_pkg::vector_hi: pc[15:8] <= rd_data;
      cpu_pkg::fetch: ir <= rd_data;
      cpu_pkg::decode: begin
        opnd_lo <= rd_data;
        if (mode == cpu_pkg::implied) begin
          pc <= pc + 16'd1;
        end else if (mode == cpu_pkg::immediate) begin
          pc <= pc + 16'd2;
        end
      end
      cpu_pkg::abs_1: begin
        if (mode == cpu_pkg::jump) begin
          pc <= {rd_data, opnd_lo};
        end
        wr_data <= store_data;
      end
      cpu_pkg::abs_2: pc <= pc + 16'd3;
      default: begin
      end
    endcase
  end

endmodule

// ==== cpu_top.sv ====
// Top level of the reduced 6502 core
// Sequencer, opcode decoder and register block with its ALU

`timescale 1ns/1ns

module cpu_top #(
  parameter cpu_pkg::addr_t VECTOR_ADDR = 16'hfffc
) (
  input  logic           clk,
  input  logic           resetn,
  input  cpu_pkg::data_t rd_data,
  output cpu_pkg::addr_t address,
  output cpu_pkg::data_t wr_data,
  output logic           wr_enable,
  output logic           sync,
  output logic           halted,
  output cpu_pkg::data_t status
);

  // Decode results
  cpu_pkg::addr_mode_t mode;
  cpu_pkg::alu_op_t    alu_op;
  cpu_pkg::reg_sel_t   dest;
  cpu_pkg::reg_sel_t   store_src;
  cpu_pkg::flag_cls_t  flag_cls;
  // Sequencer to register block
  cpu_pkg::data_t      ir;
  cpu_pkg::data_t      operand;
  cpu_pkg::data_t      store_data;
  logic                reg_write;

  cpu_sequencer #(
    .VECTOR_ADDR (VECTOR_ADDR)
  ) u_seq (
    .clk        (clk),
    .resetn     (resetn),
    .rd_data    (rd_data),
    .mode       (mode),
    .store_src  (store_src),
    .store_data (store_data),
    .ir         (ir),
    .operand    (operand),
    .reg_write  (reg_write),
    .address    (address),
    .wr_data    (wr_data),
    .wr_enable  (wr_enable),
    .sync       (sync),
    .halted     (halted)
  );

  opcode_decoder u_dec (
    .ir        (ir),
    .mode      (mode),
    .alu_op    (alu_op),
    .dest      (dest),
    .store_src (store_src),
    .flag_cls  (flag_cls)
  );

  cpu_regs u_regs (
    .clk        (clk),
    .resetn     (resetn),
    .reg_write  (reg_write),
    .operand    (operand),
    .ir         (ir),
    .alu_op     (alu_op),
    .dest       (dest),
    .flag_cls   (flag_cls),
    .store_src  (store_src),
    .store_data (store_data),
    .status     (status)
  );

endmodule

// ==== tb_checker.sv ====
// Checker for the reduced 6502 core
// Reference instruction-set model over a copy of memory,
// and the process that compares status, timing and writes

`timescale 1ns/1ns

module tb_checker #(
  parameter logic [15:0] VECTOR_ADDR = 16'hfffc
) (
  input  logic           clk,
  input  logic           resetn,
  input  cpu_pkg::addr_t address,
  input  cpu_pkg::data_t wr_data,
  input  logic           wr_enable,
  input  logic           sync,
  input  logic           halted,
  input  cpu_pkg::data_t status,
  output int             error_count,
  output int             sync_count,
  output int             write_count,
  output logic           model_halted
);

  // Model copy of memory that the testbench top loads
  logic [7:0]  model_mem [0:65535];

  // Model registers
  logic [7:0]  m_a;
  logic [7:0]  m_x;
  logic [7:0]  m_y;
  logic [7:0]  m_p;
  logic [15:0] m_pc;
  logic        m_halted;

  // Pending store of the current instruction
  logic        exp_wr;
  logic [15:0] exp_wr_addr;
  logic [7:0]  exp_wr_data;

  int          exp_cycles;
  int          cnt;
  int          edges;
  int          errors;
  int          syncs;
  int          writes;

  assign error_count = errors;
  assign sync_count = syncs;
  assign write_count = writes;
  assign model_halted = m_halted;

  task automatic value_mismatch(input string name, input logic [15:0] got,
                                input logic [15:0] exp);
    $display("** Error at %0t ns: %s = 0x%h, expected 0x%h", $time, name, got, exp);
    errors = errors + 1;
  endtask

  task automatic protocol_fault(input string what);
    $display("Failure at %0t ns: %s", $time, what);
    errors = errors + 1;
  endtask

  function automatic logic [7:0] with_nz(input logic [7:0] p, input logic [7:0] v);
    logic [7:0] q;
    q = p;
    q[cpu_pkg::neg] = v[7];
    q[cpu_pkg::zero] = (v == 8'h00);
    return q;
  endfunction

  // ------------------------------------------------------------
  // Reference model that runs one instruction and returns its cycle count
  // ------------------------------------------------------------
  function int step_model();
    logic [7:0]  op;
    logic [7:0]  m;
    logic [15:0] ea;
    int          ua;
    int          sa;
    int          cin;
    int          cycles;
    op = model_mem[m_pc];
    ea = {model_mem[m_pc + 16'd2], model_mem[m_pc + 16'd1]};
    m = model_mem[ea];
    // Absolute instructions unless changed below
    cycles = 4;
    m_pc = m_pc + 16'd3;
    case (op)
      cpu_pkg::op_clc, cpu_pkg::op_sec, cpu_pkg::op_clv, cpu_pkg::op_nop: begin
        cycles = 2;
        m_pc = m_pc - 16'd2;
        if (op == cpu_pkg::op_clc) m_p[cpu_pkg::carry] = 1'b0;
        if (op == cpu_pkg::op_sec) m_p[cpu_pkg::carry] = 1'b1;
        if (op == cpu_pkg::op_clv) m_p[cpu_pkg::ovf] = 1'b0;
      end
      cpu_pkg::op_lda_imm, cpu_pkg::op_ldx_imm, cpu_pkg::op_ldy_imm: begin
        cycles = 2;
        m_pc = m_pc - 16'd1;
        if (op == cpu_pkg::op_lda_imm) m_a = ea[7:0];
        if (op == cpu_pkg::op_ldx_imm) m_x = ea[7:0];
        if (op == cpu_pkg::op_ldy_imm) m_y = ea[7:0];
        m_p = with_nz(m_p, ea[7:0]);
      end
      cpu_pkg::op_lda_abs: begin
        m_a = m;
        m_p = with_nz(m_p, m);
      end
      cpu_pkg::op_ldx_abs: begin
        m_x = m;
        m_p = with_nz(m_p, m);
      end
      cpu_pkg::op_ldy_abs: begin
        m_y = m;
        m_p = with_nz(m_p, m);
      end
      cpu_pkg::op_sta_abs, cpu_pkg::op_stx_abs, cpu_pkg::op_sty_abs: begin
        exp_wr = 1'b1;
        exp_wr_addr = ea;
        if (op == cpu_pkg::op_sta_abs) exp_wr_data = m_a;
        else if (op == cpu_pkg::op_stx_abs) exp_wr_data = m_x;
        else exp_wr_data = m_y;
        model_mem[ea] = exp_wr_data;
      end
      cpu_pkg::op_jmp_abs: begin
        cycles = 3;
        m_pc = ea;
      end
      cpu_pkg::op_adc_abs, cpu_pkg::op_sbc_abs: begin
        // Unsigned and signed sums worked out as plain integers
        cin = int'(m_p[cpu_pkg::carry]);
        if (op == cpu_pkg::op_sbc_abs) begin
          // Borrow is the inverse of carry
          ua = int'(m_a) - int'(m) - (1 - cin);
          sa = int'($signed(m_a)) - int'($signed(m)) - (1 - cin);
          m_p[cpu_pkg::carry] = (ua >= 0);
        end else begin
          ua = int'(m_a) + int'(m) + cin;
          sa = int'($signed(m_a)) + int'($signed(m)) + cin;
          m_p[cpu_pkg::carry] = (ua > 255);
        end
        // Overflow when the signed result leaves -128 to 127
        m_p[cpu_pkg::ovf] = (sa > 127) || (sa < -128);
        m_a = ua[7:0];
        m_p = with_nz(m_p, m_a);
      end
      cpu_pkg::op_and_abs: begin
        m_a = m_a & m;
        m_p = with_nz(m_p, m_a);
      end
      cpu_pkg::op_ora_abs: begin
        m_a = m_a | m;
        m_p = with_nz(m_p, m_a);
      end
      cpu_pkg::op_eor_abs: begin
        m_a = m_a ^ m;
        m_p = with_nz(m_p, m_a);
      end
      default: begin
        // Illegal opcode takes fetch and decode before the trap
        cycles = 2;
        m_halted = 1'b1;
      end
    endcase
    return cycles;
  endfunction

  // ------------------------------------------------------------
  // Compare process sampling DUT outputs at the rising edge
  // ------------------------------------------------------------
  always @(posedge clk) begin
    if (!resetn) begin
      m_a = 8'h00;
      m_x = 8'h00;
      m_y = 8'h00;
      m_p = 8'h20;
      m_pc = {model_mem[VECTOR_ADDR + 16'd1], model_mem[VECTOR_ADDR]};
      m_halted = 1'b0;
      exp_wr = 1'b0;
      cnt = 0;
      edges = 0;
    end else begin
      edges = edges + 1;
      // First cycle after reset is the reset state
      if (edges == 1 && address !== VECTOR_ADDR) begin
        value_mismatch("address", address, VECTOR_ADDR);
      end
      if (halted !== (m_halted && cnt >= 2)) begin
        value_mismatch("halted", {15'd0, halted}, {15'd0, m_halted && cnt >= 2});
      end
      if (wr_enable === 1'b1) begin
        if (!exp_wr) begin
          protocol_fault("write enable high with no store pending");
        end else begin
          if (address !== exp_wr_addr) value_mismatch("address", address, exp_wr_addr);
          if (wr_data !== exp_wr_data) begin
            value_mismatch("wr_data", {8'h00, wr_data}, {8'h00, exp_wr_data});
          end
          exp_wr = 1'b0;
          writes = writes + 1;
        end
      end else if (wr_enable !== 1'b0) begin
        protocol_fault("write enable is unknown");
      end
      if (sync === 1'b1) begin
        if (m_halted) begin
          protocol_fault("sync seen after the trap opcode");
        end else begin
          if (syncs == 0 && edges != 4) begin
            value_mismatch("cycles to first sync", edges[15:0], 16'd4);
          end
          if (syncs > 0 && cnt != exp_cycles) begin
            value_mismatch("cycles since sync", cnt[15:0], exp_cycles[15:0]);
          end
          if (exp_wr) begin
            protocol_fault("store finished without a write");
            exp_wr = 1'b0;
          end
          if (status !== m_p) value_mismatch("status", {8'h00, status}, {8'h00, m_p});
          if (address !== m_pc) value_mismatch("address", address, m_pc);
          exp_cycles = step_model();
          cnt = 1;
          syncs = syncs + 1;
        end
      end else if (syncs > 0) begin
        cnt = cnt + 1;
      end
    end
  end

  initial begin
    errors = 0;
    syncs = 0;
    writes = 0;
    m_halted = 1'b0;
  end

endmodule

// ==== tb_top.sv ====
// Testbench top for the reduced 6502 core
// Clock, reset, memory model, LFSR program generator,
// DUT instance, checker instance and watchdog

`timescale 1ns/1ns

module tb_top;

  localparam logic [15:0] VECTOR_ADDR = 16'hfffc;
  localparam int num_instr = 200;
  localparam int clk_period = 8;
  // Four cycles per instruction, trap opcode included, reset and margin
  localparam int timeout_cycles = 4 * (num_instr + 1) + 4 + 200;

  logic           clk;
  logic           resetn;
  cpu_pkg::data_t rd_data;
  cpu_pkg::addr_t address;
  cpu_pkg::data_t wr_data;
  logic           wr_enable;
  logic           sync;
  logic           halted;
  cpu_pkg::data_t status;

  int             error_count;
  int             sync_count;
  int             write_count;
  logic           model_halted;

  logic [7:0]     mem [0:65535];
  logic [15:0]    lfsr;

  // ------------------------------------------------------------
  // Clock and memory
  // ------------------------------------------------------------
  initial begin
    clk = 1'b0;
    forever #(clk_period / 2) clk = ~clk;
  end

  // Read data follows the registered address in the same cycle
  assign rd_data = mem[address];

  always @(posedge clk) begin
    if (wr_enable === 1'b1) begin
      mem[address] <= wr_data;
    end
  end

  cpu_top #(
    .VECTOR_ADDR (VECTOR_ADDR)
  ) uut (
    .clk       (clk),
    .resetn    (resetn),
    .rd_data   (rd_data),
    .address   (address),
    .wr_data   (wr_data),
    .wr_enable (wr_enable),
    .sync      (sync),
    .halted    (halted),
    .status    (status)
  );

  tb_checker #(
    .VECTOR_ADDR (VECTOR_ADDR)
  ) chk (
    .clk          (clk),
    .resetn       (resetn),
    .address      (address),
    .wr_data      (wr_data),
    .wr_enable    (wr_enable),
    .sync         (sync),
    .halted       (halted),
    .status       (status),
    .error_count  (error_count),
    .sync_count   (sync_count),
    .write_count  (write_count),
    .model_halted (model_halted)
  );

  // ------------------------------------------------------------
  // Program generator
  // ------------------------------------------------------------
  // Fibonacci LFSR, taps 16 14 13 11
  function automatic logic [15:0] lfsr_step(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  // One LFSR step per bit taken
  task automatic take_bits(input int n, output logic [15:0] v);
    v = '0;
    for (int k = 0; k < n; k++) begin
      lfsr = lfsr_step(lfsr);
      v = {v[14:0], lfsr[0]};
    end
  endtask

  // Same byte into the memory model and the checker's copy
  task automatic put_byte(input logic [15:0] addr, input logic [7:0] data);
    mem[addr] = data;
    chk.model_mem[addr] = data;
  endtask

  function automatic logic [7:0] pick_opcode(input logic [4:0] sel);
    case (sel % 19)
      0: return cpu_pkg::op_clc;
      1: return cpu_pkg::op_sec;
      2: return cpu_pkg::op_clv;
      3: return cpu_pkg::op_nop;
      4: return cpu_pkg::op_lda_imm;
      5: return cpu_pkg::op_ldx_imm;
      6: return cpu_pkg::op_ldy_imm;
      7: return cpu_pkg::op_lda_abs;
      8: return cpu_pkg::op_ldx_abs;
      9: return cpu_pkg::op_ldy_abs;
      10: return cpu_pkg::op_sta_abs;
      11: return cpu_pkg::op_stx_abs;
      12: return cpu_pkg::op_sty_abs;
      13: return cpu_pkg::op_jmp_abs;
      14: return cpu_pkg::op_adc_abs;
      15: return cpu_pkg::op_sbc_abs;
      16: return cpu_pkg::op_and_abs;
      17: return cpu_pkg::op_ora_abs;
      default: return cpu_pkg::op_eor_abs;
    endcase
  endfunction

  task automatic build_program();
    logic [15:0] pc;
    logic [15:0] v;
    logic [15:0] target;
    logic [7:0]  op;
    // Background fill built from both address bytes
    for (int i = 0; i < 65536; i++) begin
      put_byte(i[15:0], i[15:8] ^ i[7:0] ^ 8'ha5);
    end
    // Data page 0x0200 to 0x02ff
    for (int i = 0; i < 256; i++) begin
      take_bits(8, v);
      put_byte({8'h02, i[7:0]}, v[7:0]);
    end
    put_byte(VECTOR_ADDR, 8'h00);
    put_byte(VECTOR_ADDR + 16'd1, 8'h04);
    // A has no reset, so the program loads it first
    pc = 16'h0400;
    take_bits(8, v);
    put_byte(pc, cpu_pkg::op_lda_imm);
    put_byte(pc + 16'd1, v[7:0]);
    pc = pc + 16'd2;
    for (int n = 1; n < num_instr; n++) begin
      take_bits(5, v);
      op = pick_opcode(v[4:0]);
      put_byte(pc, op);
      case (op)
        cpu_pkg::op_clc, cpu_pkg::op_sec, cpu_pkg::op_clv, cpu_pkg::op_nop: begin
          pc = pc + 16'd1;
        end
        cpu_pkg::op_lda_imm, cpu_pkg::op_ldx_imm, cpu_pkg::op_ldy_imm: begin
          take_bits(8, v);
          put_byte(pc + 16'd1, v[7:0]);
          pc = pc + 16'd2;
        end
        cpu_pkg::op_jmp_abs: begin
          // Forward by 0 to 3 bytes, skipped bytes hold the trap opcode
          take_bits(2, v);
          target = pc + 16'd3 + {14'd0, v[1:0]};
          put_byte(pc + 16'd1, target[7:0]);
          put_byte(pc + 16'd2, target[15:8]);
          for (logic [15:0] p = pc + 16'd3; p != target; p++) begin
            put_byte(p, 8'h02);
          end
          pc = target;
        end
        default: begin
          take_bits(8, v);
          put_byte(pc + 16'd1, v[7:0]);
          put_byte(pc + 16'd2, 8'h02);
          pc = pc + 16'd3;
        end
      endcase
    end
    put_byte(pc, 8'h02);
  endtask

  // ------------------------------------------------------------
  // Stimulus and end of run
  // ------------------------------------------------------------
  initial begin
    int end_errors;
    resetn = 1'b0;
    lfsr = 16'd37;
    build_program();
    repeat (4) @(posedge clk);
    resetn <= 1'b1;
    wait (halted === 1'b1);
    // Trap must hold with no sync or write
    repeat (20) @(posedge clk);
    end_errors = error_count;
    if (!model_halted) begin
      $display("Failure: the reference model never reached the trap opcode");
      end_errors = end_errors + 1;
    end
    $display("Run complete: %0d instructions, %0d writes, %0d errors",
             sync_count, write_count, end_errors);
    if (end_errors == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

  // Watchdog
  initial begin
    #(timeout_cycles * clk_period);
    $display("Timeout: the core did not reach the trap state within %0d cycles",
             timeout_cycles);
    $display("Errors found");
    $finish;
  end

endmodule

// ==== list.f ====
cpu_pkg.sv
cpu_alu.sv
opcode_decoder.sv
cpu_regs.sv
cpu_sequencer.sv
cpu_top.sv
tb_checker.sv
tb_top.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing
TOP       := tb_top
FILELIST  := list.f
SIM_DIR   := obj_dir
SIM       := $(SIM_DIR)/V$(TOP)
LOG       := sim.log
SOURCES   := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

# Rebuilt only when a source or the file list changes
$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(SIM_DIR)

run: $(SIM)
	./$(SIM) | tee $(LOG)
	@grep -q "^No errors$$" $(LOG) || (echo "Simulation failed"; exit 1)

clean:
	rm -rf $(SIM_DIR) $(LOG)
